// File: list.f
verilog/dcache_cfg_pkg.sv
verilog/dcache_bus_pkg.sv
verilog/dcache_tag_store.sv
verilog/dcache_data_store.sv
verilog/dcache_wb_buffer.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
test/dcache_mem_model.sv
test/tb_dcache.sv

// File: Makefile
TOP = tb_dcache
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "all tests passed" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_dcache.sv
/*
 * testbench for the write-back data cache
 * clock, reset, LCG stimulus, reference memory and cache state model,
 * compare tasks and the final report
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;
();

  localparam int wait_limit = 5000;
  localparam int ref_words = 4096;

  logic                 bus_clk = 1'b0;
  logic                 resetn;
  cpu_req_t             cpu_req;
  logic                 bus_wait;
  logic [31:0]          readdata;
  logic [line_bits-1:0] readdata_line;
  logic                 cache_hit;
  logic                 cache_miss;
  logic                 flush_done;
  mem_req_t             mem_req;
  logic                 mem_ready;
  mem_rsp_t             mem_rsp;

  // flat reference memory plus the expected cache contents
  logic [31:0]          ref_mem [ref_words];
  logic [tag_bits-1:0]  model_tag [depth];
  logic [depth-1:0]     model_valid;
  logic [depth-1:0]     model_dirty;
  logic [31:0]          seed;
  int                   errors;
  int                   checks;
  int                   test_base;
  int                   exp_wb_beats;
  // every accepted write beat
  mem_req_t             wr_log [$];

  always #2 bus_clk = ~bus_clk;

  dcache_top u_dcache_top (
    .bus_clk       (bus_clk),
    .resetn        (resetn),
    .cpu_req       (cpu_req),
    .bus_wait      (bus_wait),
    .readdata      (readdata),
    .readdata_line (readdata_line),
    .cache_hit     (cache_hit),
    .cache_miss    (cache_miss),
    .flush_done    (flush_done),
    .mem_req       (mem_req),
    .mem_ready     (mem_ready),
    .mem_rsp       (mem_rsp)
  );

  dcache_mem_model u_mem (
    .bus_clk   (bus_clk),
    .resetn    (resetn),
    .mem_req   (mem_req),
    .mem_ready (mem_ready),
    .mem_rsp   (mem_rsp)
  );

  always @(posedge bus_clk)
  begin
    if (resetn && mem_req.valid && mem_ready && mem_req.op == op_write)
      wr_log.push_back(mem_req);
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // same preset rule as the memory model
  function automatic logic [31:0] preset_word(input logic [31:0] a);
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a0f0f;
  endfunction

  function automatic logic [line_bits-1:0] ref_line(input logic [31:0] a);
    logic [line_bits-1:0] l;
    for (int w = 0; w < line_words; w++)
      l[w*32 +: 32] = ref_mem[{a[13:4], 2'(w)}];
    return l;
  endfunction

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_line(input logic [line_bits-1:0] got, input logic [line_bits-1:0] exp,
                            input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_mem_req(input mem_req_t got, input mem_req_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t: %s got addr %h data %h op %0d, expected addr %h data %h op %0d",
               $time, what, got.addr, got.wdata, got.op, exp.addr, exp.wdata, exp.op);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAILED %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp)
    begin
      errors++;
      $display("FAILED %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    $display("tests failed");
    $finish;
  endtask

  task automatic begin_test();
    test_base = errors;
  endtask

  task automatic report_test(input string name);
    if (errors == test_base)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - test_base);
  endtask

  // updates the cache model and reference memory, returns the expected hit
  task automatic predict_access(input logic [31:0] addr, input logic wr,
                                input logic [line_bytes-1:0] be,
                                input logic [line_bits-1:0] wd, output logic exp_hit);
    int                  set;
    logic [tag_bits-1:0] tag;
    set = int'(addr[index_lsb +: index_bits]);
    tag = addr[tag_lsb +: tag_bits];
    exp_hit = model_valid[set] && (model_tag[set] == tag);
    if (!exp_hit)
    begin
      // dirty victim goes out as four beats
      if (model_valid[set] && model_dirty[set])
        exp_wb_beats += beats_per_line;
      model_valid[set] = 1'b1;
      model_dirty[set] = 1'b0;
      model_tag[set] = tag;
    end
    if (wr)
    begin
      for (int b = 0; b < line_bytes; b++)
      begin
        if (be[b])
          ref_mem[{addr[13:4], 2'(b / 4)}][(b % 4)*8 +: 8] = wd[b*8 +: 8];
      end
      model_dirty[set] = 1'b1;
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic drive_access(input logic [31:0] addr, input logic wr,
                              input logic [line_bytes-1:0] be,
                              input logic [line_bits-1:0] wd, output logic miss_seen,
                              output logic [31:0] word, output logic [line_bits-1:0] line,
                              output int cycles);
    cpu_req.en = 1'b1;
    cpu_req.wren = wr;
    cpu_req.flush = 1'b0;
    cpu_req.address = addr;
    cpu_req.byteen = be;
    cpu_req.writedata = wd;
    cycles = 0;
    miss_seen = 1'b0;
    do
    begin
      @(negedge bus_clk);
      cycles++;
      if (cache_miss)
        miss_seen = 1'b1;
      // cpu stalled for the whole miss
      if (!cache_hit)
        check_bit(bus_wait, 1'b1, "bus_wait during miss");
    end
    while (!cache_hit && cycles < wait_limit);
    if (!cache_hit)
      abort_on_timeout("cache_hit on a cpu access");
    check_bit(bus_wait, 1'b0, "bus_wait with cache_hit");
    word = readdata;
    line = readdata_line;
    // request stays up through the lookup edge
    @(negedge bus_clk);
    cpu_req.en = 1'b0;
    cpu_req.wren = 1'b0;
  endtask

  task automatic run_access(input logic [31:0] addr, input logic wr,
                            input logic [line_bytes-1:0] be, input logic [line_bits-1:0] wd,
                            output logic [31:0] word, output int cycles);
    logic                 exp_hit;
    logic                 miss_seen;
    logic [line_bits-1:0] line;
    predict_access(addr, wr, be, wd, exp_hit);
    drive_access(addr, wr, be, wd, miss_seen, word, line, cycles);
    check_bit(miss_seen, !exp_hit, "cache_miss on lookup");
    // a hit answers in the first lookup cycle, a miss never does
    check_bit(cycles == 1, exp_hit, "cache_hit in the first lookup");
    if (!wr)
    begin
      check_word(word, ref_mem[addr[13:2]], "read word");
      check_line(line, ref_line(addr), "read line");
    end
  endtask

  task automatic run_random_access(input logic allow_read);
    logic [31:0]          r;
    logic [31:0]          addr;
    logic [line_bits-1:0] wd;
    logic [31:0]          word;
    int                   cycles;
    r = lcg_next();
    addr = {20'd0, r[27:18], 2'b00};
    for (int w = 0; w < line_words; w++)
      wd[w*32 +: 32] = lcg_next();
    r = lcg_next();
    run_access(addr, !allow_read || r[31], r[23:8], wd, word, cycles);
  endtask

  task automatic wait_writes(input int n);
    int cnt;
    cnt = 0;
    while (wr_log.size() < n && cnt < wait_limit)
    begin
      @(negedge bus_clk);
      cnt++;
    end
    if (wr_log.size() < n)
      abort_on_timeout("writeback beats");
  endtask

  // flush, then memory must equal the reference
  task automatic run_flush();
    int n;
    int dirty_lines;
    dirty_lines = 0;
    for (int s = 0; s < depth; s++)
    begin
      if (model_valid[s] && model_dirty[s])
        dirty_lines++;
    end
    model_valid = '0;
    model_dirty = '0;
    exp_wb_beats += beats_per_line * dirty_lines;
    cpu_req.en = 1'b1;
    cpu_req.flush = 1'b1;
    cpu_req.wren = 1'b0;
    n = 0;
    do
    begin
      @(negedge bus_clk);
      n++;
    end
    while (!flush_done && n < wait_limit);
    if (!flush_done)
      abort_on_timeout("flush_done");
    @(negedge bus_clk);
    cpu_req.en = 1'b0;
    cpu_req.flush = 1'b0;
    check_count(wr_log.size(), exp_wb_beats, "write beats seen");
    for (int i = 0; i < ref_words; i++)
      check_word(u_mem.words[i], ref_mem[i], "memory word after flush");
  endtask

  initial
  begin
    logic [31:0] word;
    int          cycles;
    int          base;
    mem_req_t    exp_req;
    seed = 32'd14283;
    errors = 0;
    checks = 0;
    exp_wb_beats = 0;
    model_valid = '0;
    model_dirty = '0;
    for (int i = 0; i < ref_words; i++)
      ref_mem[i] = preset_word(32'(i) << 2);
    resetn = 1'b0;
    cpu_req = '0;
    repeat (5) @(posedge bus_clk);
    @(negedge bus_clk);
    resetn = 1'b1;
    @(negedge bus_clk);

    // read miss from preset memory, then a one-cycle hit
    begin_test();
    run_access(32'h100, 1'b0, '0, '0, word, cycles);
    check_word(word, preset_word(32'h100), "preset word");
    run_access(32'h104, 1'b0, '0, '0, word, cycles);
    check_count(cycles, 1, "hit latency");
    report_test("read miss then hit");

    // byte merges on one line
    begin_test();
    run_access(32'h240, 1'b1, 16'h00f0, {lcg_next(), lcg_next(), lcg_next(), lcg_next()},
               word, cycles);
    run_access(32'h240, 1'b1, 16'h0306, {lcg_next(), lcg_next(), lcg_next(), lcg_next()},
               word, cycles);
    run_access(32'h244, 1'b0, '0, '0, word, cycles);
    run_access(32'h248, 1'b0, '0, '0, word, cycles);
    run_access(32'h240, 1'b0, '0, '0, word, cycles);
    report_test("byte enabled writes");

    // same index, other tag, dirty line leaves as four beats
    begin_test();
    base = wr_log.size();
    run_access(32'h640, 1'b0, '0, '0, word, cycles);
    wait_writes(base + beats_per_line);
    for (int k = 0; k < beats_per_line; k++)
    begin
      exp_req.valid = 1'b1;
      exp_req.op = op_write;
      exp_req.addr = 32'h240 + 32'(4 * k);
      exp_req.wdata = ref_mem[(32'h240 >> 2) + k];
      check_mem_req(wr_log[base + k], exp_req, "writeback beat");
    end
    run_access(32'h240, 1'b0, '0, '0, word, cycles);
    report_test("dirty eviction");

    // read back a line still waiting in the writeback buffer
    begin_test();
    run_access(32'h380, 1'b1, 16'hffff, {lcg_next(), lcg_next(), lcg_next(), lcg_next()},
               word, cycles);
    run_access(32'h780, 1'b0, '0, '0, word, cycles);
    run_access(32'h380, 1'b0, '0, '0, word, cycles);
    report_test("fill behind writeback");

    begin_test();
    for (int i = 0; i < 40; i++)
      run_random_access(1'b0);
    run_flush();
    report_test("flush");

    // mixed traffic with memory stalls
    begin_test();
    for (int i = 0; i < 1000; i++)
      run_random_access(1'b1);
    run_flush();
    report_test("random traffic");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: test/dcache_mem_model.sv
/*
 * memory model for the data cache testbench
 * word array with address-based preset, random ready stalls,
 * four-beat read bursts and single-word writes
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model
  import dcache_bus_pkg::*;
(
  input  wire           bus_clk,
  input  wire           resetn,
  input  wire mem_req_t mem_req,
  output logic          mem_ready,
  output mem_rsp_t      mem_rsp
);

  // 16 KB window, all test addresses fall inside
  localparam int mem_words = 4096;

  logic [31:0] words [mem_words];
  logic [31:0] rand_q;
  // pending read burst
  logic [31:0] rd_base;
  logic [2:0]  rd_left;
  logic [1:0]  rd_beat;

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // mixes every address bit
  function automatic logic [31:0] preset_word(input logic [31:0] a);
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a0f0f;
  endfunction

  initial
  begin
    rand_q = 32'd14283;
    rd_base = '0;
    rd_left = '0;
    rd_beat = '0;
    mem_ready = 1'b0;
    mem_rsp = '0;
    for (int i = 0; i < mem_words; i++)
      words[i] = preset_word(32'(i) << 2);
  end

  // outputs change on the falling edge, away from the sampling edge
  always @(negedge bus_clk)
  begin
    rand_q = next_rand(rand_q);
    if (!resetn)
    begin
      mem_ready = 1'b0;
      mem_rsp = '0;
    end
    else
    begin
      // ready about three cycles in four
      mem_ready = (rand_q[30:29] != 2'b00);
      // beats spaced at random
      if (rd_left != 3'd0 && rand_q[27:26] != 2'b00)
      begin
        mem_rsp.rvalid = 1'b1;
        mem_rsp.rdata = words[{rd_base[13:4], rd_beat}];
      end
      else
        mem_rsp = '0;
    end
  end

  always @(posedge bus_clk)
  begin
    // the cache takes every beat it sees
    if (mem_rsp.rvalid)
    begin
      rd_left = rd_left - 3'd1;
      rd_beat = rd_beat + 2'd1;
    end
    if (resetn && mem_req.valid && mem_ready)
    begin
      if (mem_req.op == op_write)
        words[mem_req.addr[13:2]] = mem_req.wdata;
      else
      begin
        rd_base = mem_req.addr;
        rd_left = 3'd4;
        rd_beat = 2'd0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/dcache_top.sv
/*
 * data cache top level
 * controller, tag store, data store and writeback buffer
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_top
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;
(
  input  wire                 bus_clk,
  input  wire                 resetn,
  input  wire cpu_req_t       cpu_req,
  output logic                bus_wait,
  output logic [31:0]         readdata,
  output logic [line_bits-1:0] readdata_line,
  output logic                cache_hit,
  output logic                cache_miss,
  output logic                flush_done,
  output mem_req_t            mem_req,
  input  wire                 mem_ready,
  input  wire mem_rsp_t       mem_rsp
);

  logic [index_bits-1:0] index;
  logic                  tag_write;
  logic                  dirty_set;
  logic                  invalidate;
  logic                  cpu_write;
  logic                  fill_we;
  logic [beat_bits-1:0]  fill_beat;
  logic                  victim_load;
  logic [31:0]           fill_addr;
  logic                  wb_grant;
  logic                  hit;
  logic                  victim_dirty;
  logic [tag_bits-1:0]   victim_tag;
  logic                  wb_busy;
  logic                  fill_conflict;
  mem_req_t              wb_req;

  dcache_ctrl u_ctrl (
    .bus_clk       (bus_clk),
    .resetn        (resetn),
    .cpu_req       (cpu_req),
    .hit           (hit),
    .victim_dirty  (victim_dirty),
    .wb_busy       (wb_busy),
    .fill_conflict (fill_conflict),
    .wb_req        (wb_req),
    .mem_ready     (mem_ready),
    .mem_rsp       (mem_rsp),
    .index         (index),
    .tag_write     (tag_write),
    .dirty_set     (dirty_set),
    .invalidate    (invalidate),
    .cpu_write     (cpu_write),
    .fill_we       (fill_we),
    .fill_beat     (fill_beat),
    .victim_load   (victim_load),
    .fill_addr     (fill_addr),
    .wb_grant      (wb_grant),
    .mem_req       (mem_req),
    .bus_wait      (bus_wait),
    .cache_hit     (cache_hit),
    .cache_miss    (cache_miss),
    .flush_done    (flush_done)
  );

  // lookup and refill both use the held request tag
  dcache_tag_store u_tag_store (
    .bus_clk      (bus_clk),
    .resetn       (resetn),
    .index        (index),
    .lookup_tag   (cpu_req.address[tag_lsb +: tag_bits]),
    .tag_write    (tag_write),
    .tag_value    (cpu_req.address[tag_lsb +: tag_bits]),
    .dirty_set    (dirty_set),
    .invalidate   (invalidate),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .victim_tag   (victim_tag)
  );

  dcache_data_store u_data_store (
    .bus_clk   (bus_clk),
    .index     (index),
    .byteen    (cpu_req.byteen),
    .writedata (cpu_req.writedata),
    .cpu_write (cpu_write),
    .fill_word (mem_rsp.rdata),
    .fill_beat (fill_beat),
    .fill_we   (fill_we),
    .word_sel  (cpu_req.address[word_lsb +: word_sel_bits]),
    .line      (readdata_line),
    .word      (readdata)
  );

  // victim address rebuilt from stored tag and current set
  dcache_wb_buffer u_wb_buffer (
    .bus_clk       (bus_clk),
    .resetn        (resetn),
    .victim_load   (victim_load),
    .victim_addr   ({victim_tag, index, {offset_bits{1'b0}}}),
    .victim_line   (readdata_line),
    .fill_addr     (fill_addr),
    .wb_grant      (wb_grant),
    .mem_ready     (mem_ready),
    .wb_req        (wb_req),
    .wb_busy       (wb_busy),
    .fill_conflict (fill_conflict)
  );

endmodule

`default_nettype wire

// File: verilog/dcache_ctrl.sv
/*
 * cache controller FSM
 * lookup, victim capture, fill, refill, flush walk
 * and memory port arbitration between fill reads and writebacks
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;
(
  input  wire                   bus_clk,
  input  wire                   resetn,
  input  wire cpu_req_t         cpu_req,
  input  wire                   hit,
  input  wire                   victim_dirty,
  input  wire                   wb_busy,
  input  wire                   fill_conflict,
  input  wire mem_req_t         wb_req,
  input  wire                   mem_ready,
  input  wire mem_rsp_t         mem_rsp,
  output logic [index_bits-1:0] index,
  output logic                  tag_write,
  output logic                  dirty_set,
  output logic                  invalidate,
  output logic                  cpu_write,
  output logic                  fill_we,
  output logic [beat_bits-1:0]  fill_beat,
  output logic                  victim_load,
  output logic [31:0]           fill_addr,
  output logic                  wb_grant,
  output mem_req_t              mem_req,
  output logic                  bus_wait,
  output logic                  cache_hit,
  output logic                  cache_miss,
  output logic                  flush_done
);

  localparam logic [beat_bits-1:0] last_beat = beat_bits'(beats_per_line - 1);

  ctrl_state_e           state;
  ctrl_state_e           state_n;
  logic [31:0]           addr_q;
  logic [index_bits-1:0] flush_cnt;
  logic                  scan_phase;
  logic [beat_bits-1:0]  fill_beat_q;
  logic                  wb_hold_q;
  logic                  fill_go;

  assign fill_addr = {addr_q[31:offset_bits], {offset_bits{1'b0}}};
  assign fill_beat = fill_beat_q;

  // fill read waits for a conflicting victim and for a stalled wb beat
  assign fill_go = (state == st_fill_req) & ~fill_conflict & ~wb_hold_q;
  // buffer owns the port unless a fill is outstanding
  assign wb_grant = ~(fill_go | (state == st_fill));

  assign cache_hit = (state == st_lookup) & hit;
  assign cache_miss = (state == st_lookup) & ~hit;

  always_comb
  begin
    case (state)
      st_idle:       index = cpu_req.address[index_lsb +: index_bits];
      st_flush_scan: index = flush_cnt;
      st_flush_wait: index = flush_cnt;
      default:       index = addr_q[index_lsb +: index_bits];
    endcase
  end

  always_comb
  begin
    case (state)
      st_idle:       bus_wait = 1'b0;
      st_lookup:     bus_wait = ~hit;
      st_flush_wait: bus_wait = wb_busy;
      default:       bus_wait = 1'b1;
    endcase
  end

  // memory port mux
  always_comb
  begin
    mem_req = '0;
    if (fill_go)
    begin
      mem_req.valid = 1'b1;
      mem_req.op = op_read;
      mem_req.addr = fill_addr;
    end
    else if (wb_grant)
      mem_req = wb_req;
  end

  always_comb
  begin
    state_n = state;
    tag_write = 1'b0;
    dirty_set = 1'b0;
    invalidate = 1'b0;
    cpu_write = 1'b0;
    fill_we = 1'b0;
    victim_load = 1'b0;
    flush_done = 1'b0;
    case (state)
      st_idle:
        if (cpu_req.en)
          state_n = cpu_req.flush ? st_flush_scan : st_lookup;
      st_lookup:
        if (hit)
        begin
          // write hit merges bytes and marks the line
          cpu_write = cpu_req.wren;
          dirty_set = cpu_req.wren;
          state_n = st_idle;
        end
        else if (victim_dirty)
          state_n = st_capture;
        else
          state_n = st_fill_req;
      // victim line and tag are still on the store outputs
      st_capture:
        if (!wb_busy)
        begin
          victim_load = 1'b1;
          state_n = st_fill_req;
        end
      st_fill_req:
        if (fill_go && mem_ready)
          state_n = st_fill;
      st_fill:
        if (mem_rsp.rvalid)
        begin
          fill_we = 1'b1;
          // tag goes in with the last beat
          if (fill_beat_q == last_beat)
          begin
            tag_write = 1'b1;
            state_n = st_refill_write;
          end
        end
      // re-read the new line before the second lookup
      st_refill_write:
        state_n = st_lookup;
      st_flush_scan:
        if (scan_phase && !(victim_dirty && wb_busy))
        begin
          victim_load = victim_dirty;
          invalidate = 1'b1;
          if (&flush_cnt)
            state_n = st_flush_wait;
        end
      st_flush_wait:
        if (!wb_busy)
        begin
          flush_done = 1'b1;
          state_n = st_idle;
        end
      default:
        state_n = st_idle;
    endcase
  end

  always_ff @(posedge bus_clk or negedge resetn)
  begin
    if (!resetn)
    begin
      state <= st_idle;
      flush_cnt <= '0;
      scan_phase <= 1'b0;
      fill_beat_q <= '0;
      wb_hold_q <= 1'b0;
    end
    else
    begin
      state <= state_n;
      // wb beat shown but not taken, must stay on the port
      wb_hold_q <= wb_grant & wb_req.valid & ~mem_ready;
      if (state == st_idle)
      begin
        flush_cnt <= '0;
        scan_phase <= 1'b0;
      end
      else if (state == st_flush_scan)
      begin
        // first cycle reads the set, second one acts on it
        if (!scan_phase)
          scan_phase <= 1'b1;
        else if (invalidate)
        begin
          scan_phase <= 1'b0;
          flush_cnt <= flush_cnt + 1'b1;
        end
      end
      if (state == st_fill_req)
        fill_beat_q <= '0;
      else if (fill_we)
        fill_beat_q <= fill_beat_q + 1'b1;
    end
  end

  // request address for index and fill
  always_ff @(posedge bus_clk)
  begin
    if (state == st_idle && cpu_req.en)
      addr_q <= cpu_req.address;
  end

endmodule

`default_nettype wire

// File: verilog/dcache_wb_buffer.sv
/*
 * one-line writeback buffer
 * holds a victim line, drains it as word beats on the memory port,
 * flags a fill that targets the held line
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_wb_buffer
  import dcache_cfg_pkg::*;
  import dcache_bus_pkg::*;
(
  input  wire                   bus_clk,
  input  wire                   resetn,
  input  wire                   victim_load,
  input  wire [31:0]            victim_addr,
  input  wire [line_bits-1:0]   victim_line,
  input  wire [31:0]            fill_addr,
  input  wire                   wb_grant,
  input  wire                   mem_ready,
  output mem_req_t              wb_req,
  output logic                  wb_busy,
  output logic                  fill_conflict
);

  localparam logic [beat_bits-1:0] last_beat = beat_bits'(beats_per_line - 1);

  // held victim, payload only
  logic [line_bits-1:0]      line_q;
  logic [31:offset_bits]     line_addr_q;
  logic [beat_bits-1:0]      beat_q;
  logic                      beat_done;

  // beat accepted by memory
  assign beat_done = wb_busy & wb_grant & mem_ready;

  always_ff @(posedge bus_clk)
  begin
    if (victim_load)
    begin
      line_q <= victim_line;
      line_addr_q <= victim_addr[31:offset_bits];
    end
  end

  always_ff @(posedge bus_clk or negedge resetn)
  begin
    if (!resetn)
    begin
      wb_busy <= 1'b0;
      beat_q <= '0;
    end
    else if (victim_load)
    begin
      wb_busy <= 1'b1;
      beat_q <= '0;
    end
    else if (beat_done)
    begin
      beat_q <= beat_q + 1'b1;
      // empty after the last word
      if (beat_q == last_beat)
        wb_busy <= 1'b0;
    end
  end

  // word writes at ascending addresses
  always_comb
  begin
    wb_req.valid = wb_busy;
    wb_req.op = op_write;
    wb_req.addr = {line_addr_q, beat_q, {word_lsb{1'b0}}};
    wb_req.wdata = line_q[beat_q*32 +: 32];
  end

  // memory still holds stale data for the held line
  assign fill_conflict = wb_busy & (line_addr_q == fill_addr[31:offset_bits]);

endmodule

`default_nettype wire

// File: verilog/dcache_data_store.sv
/*
 * data store: 64 x 128 line array
 * byte-enabled cpu writes, word-wide fill writes,
 * registered line read and word select
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_data_store
  import dcache_cfg_pkg::*;
(
  input  wire                     bus_clk,
  input  wire [index_bits-1:0]    index,
  input  wire [line_bytes-1:0]    byteen,
  input  wire [line_bits-1:0]     writedata,
  input  wire                     cpu_write,
  input  wire [31:0]              fill_word,
  input  wire [beat_bits-1:0]     fill_beat,
  input  wire                     fill_we,
  input  wire [word_sel_bits-1:0] word_sel,
  output logic [line_bits-1:0]    line,
  output logic [31:0]             word
);

  logic [line_bits-1:0]     line_mem [depth];
  logic [word_sel_bits-1:0] word_sel_q;

  always_ff @(posedge bus_clk)
  begin
    // merge enabled bytes of the cpu line
    if (cpu_write)
    begin
      for (int b = 0; b < line_bytes; b++)
      begin
        if (byteen[b])
          line_mem[index][b*8 +: 8] <= writedata[b*8 +: 8];
      end
    end
    // one memory beat lands at its word slot
    if (fill_we)
      line_mem[index][fill_beat*32 +: 32] <= fill_word;
    // old data on a same-cycle write
    line <= line_mem[index];
    word_sel_q <= word_sel;
  end

  // word picked from the saved select
  assign word = line[word_sel_q*32 +: 32];

endmodule

`default_nettype wire

// File: verilog/dcache_tag_store.sv
/*
 * tag store: tag array plus valid and dirty bits per set
 * registered lookup, hit compare and victim status
 */
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store
  import dcache_cfg_pkg::*;
(
  input  wire                  bus_clk,
  input  wire                  resetn,
  input  wire [index_bits-1:0] index,
  input  wire [tag_bits-1:0]   lookup_tag,
  input  wire                  tag_write,
  input  wire [tag_bits-1:0]   tag_value,
  input  wire                  dirty_set,
  input  wire                  invalidate,
  output logic                 hit,
  output logic                 victim_dirty,
  output logic [tag_bits-1:0]  victim_tag
);

  logic [tag_bits-1:0] tag_mem [depth];
  logic [depth-1:0]    valid_q;
  logic [depth-1:0]    dirty_q;

  // entry selected last cycle
  logic [tag_bits-1:0] tag_q;
  logic [tag_bits-1:0] lookup_tag_q;
  logic                valid_r;
  logic                dirty_r;

  // tag array, no reset
  always_ff @(posedge bus_clk)
  begin
    if (tag_write)
      tag_mem[index] <= tag_value;
    tag_q <= tag_mem[index];
    // keep the requested tag aligned with the read
    lookup_tag_q <= lookup_tag;
  end

  always_ff @(posedge bus_clk or negedge resetn)
  begin
    if (!resetn)
    begin
      valid_q <= '0;
      dirty_q <= '0;
      valid_r <= 1'b0;
      dirty_r <= 1'b0;
    end
    else
    begin
      // refill installs a clean line
      if (tag_write)
      begin
        valid_q[index] <= 1'b1;
        dirty_q[index] <= 1'b0;
      end
      // write hit
      if (dirty_set)
        dirty_q[index] <= 1'b1;
      // flush walk drops the set
      if (invalidate)
      begin
        valid_q[index] <= 1'b0;
        dirty_q[index] <= 1'b0;
      end
      valid_r <= valid_q[index];
      dirty_r <= dirty_q[index];
    end
  end

  assign hit = valid_r & (tag_q == lookup_tag_q);
  // only a valid dirty line needs a writeback
  assign victim_dirty = valid_r & dirty_r;
  assign victim_tag = tag_q;

endmodule

`default_nettype wire

// File: verilog/dcache_bus_pkg.sv
/*
 * bus types for the data cache
 * cpu request, memory request and response structs
 * memory opcode and controller state enums
 */
`default_nettype none

package dcache_bus_pkg;

  import dcache_cfg_pkg::*;

  // cpu side, held unchanged until bus_wait drops
  typedef struct packed {
    logic                  en;
    logic                  wren;
    logic                  flush;
    logic [31:0]           address;
    // line-wide write port with byte enables
    logic [line_bytes-1:0] byteen;
    logic [line_bits-1:0]  writedata;
  } cpu_req_t;

  typedef enum logic [0:0] {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_e;

  // memory request, transfers on valid and mem_ready
  typedef struct packed {
    logic        valid;
    mem_op_e     op;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  // one read beat per rvalid
  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_capture,
    st_fill_req,
    st_fill,
    st_refill_write,
    st_flush_scan,
    st_flush_wait
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: verilog/dcache_cfg_pkg.sv
/*
 * cache geometry for the direct-mapped write-back data cache
 * line, depth, tag and beat sizes plus address field positions
 */
`default_nettype none

package dcache_cfg_pkg;

  // one line is four 32-bit words
  localparam int line_bits = 128;
  localparam int line_bytes = line_bits / 8;
  localparam int line_words = line_bits / 32;

  // 64 sets
  localparam int log2_depth = 6;
  localparam int depth = 2 ** log2_depth;

  // address split: tag | index | offset
  localparam int offset_bits = $clog2(line_bytes);
  localparam int index_bits = log2_depth;
  localparam int tag_bits = 32 - index_bits - offset_bits;

  // memory port is one word wide, so a line moves as line_words beats
  localparam int beats_per_line = line_words;
  localparam int beat_bits = $clog2(beats_per_line);

  // word select inside a line
  localparam int word_sel_bits = $clog2(line_words);

  // lsb positions of the address fields
  localparam int word_lsb = 2;
  localparam int index_lsb = offset_bits;
  localparam int tag_lsb = offset_bits + index_bits;

endpackage

`default_nettype wire
